//--- rtl/cfgLoadPkg.sv
package cfgLoadPkg;

  // uart bit timing, short for simulation
  localparam int BIT_PERIOD = 16;
  localparam int BIT_CNT_W = $clog2(BIT_PERIOD);

  // idle cycles inside a frame before the decoder gives up
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int TIMEOUT_W = $clog2(TIMEOUT_CYCLES + 1);

  localparam logic [23:0] SYNC_HEADER = 24'h00AAFF;     // 00 AA FF on the wire
  localparam logic [19:0] CHECKSUM_TARGET = 20'h4FB00;  // expected byte sum of a good stream

  // credits granted by the sink after reset
  localparam int SINK_CREDITS = 2;
  localparam int CREDIT_W = $clog2(SINK_CREDITS + 1);

  localparam int BLINK_W = 22;  // led blink divider

  typedef struct packed {
    logic       hexMode;  // 1 = ascii hex pairs, 0 = raw bytes
    logic [6:0] opcode;
  } cmdFields_t;

  // command byte, seen whole or split into mode and opcode
  typedef union packed {
    logic [7:0] raw;
    cmdFields_t fields;
  } cmdByte_u;

  typedef struct packed {
    logic [31:0] data;
    logic [6:0]  opcode;
  } cfgWord_t;

  typedef struct packed {
    logic active;
    logic checksumOk;
    logic frameDone;
    logic overflow;
    logic badCommand;
  } loaderStatus_t;

endpackage

//--- rtl/uartRx.sv
module uartRx
  import cfgLoadPkg::*;
(
  input  logic       CLK,
  input  logic       resetn,
  input  logic       rx,
  output logic [7:0] rxByte,
  output logic       rxStrobe
);

  logic                 rxMeta;
  logic                 rxSync;
  logic                 busy;
  logic [3:0]           bitIndex;   // 0 start, 1..8 data, 9 first stop, 10 stop sample
  logic [BIT_CNT_W-1:0] tickCount;  // cycles left to the next sample point
  logic [7:0]           shiftReg;
  logic                 sampleNow;

  assign sampleNow = busy && (tickCount == '0);

  // two-flop synchronizer, line idles high
  always_ff @(posedge CLK or negedge resetn) begin
    if (!resetn) begin
      rxMeta <= 1'b1;
      rxSync <= 1'b1;
    end else begin
      rxMeta <= rx;
      rxSync <= rxMeta;
    end
  end

  always_ff @(posedge CLK or negedge resetn) begin
    if (!resetn) begin
      busy      <= 1'b0;
      bitIndex  <= '0;
      tickCount <= '0;
      rxStrobe  <= 1'b0;
    end else begin
      rxStrobe <= 1'b0;
      if (!busy) begin
        if (!rxSync) begin
          busy      <= 1'b1;
          bitIndex  <= '0;
          tickCount <= BIT_CNT_W'(BIT_PERIOD / 2 - 1);  // first sample at mid start bit
        end
      end else if (sampleNow) begin
        tickCount <= BIT_CNT_W'(BIT_PERIOD - 1);
        bitIndex  <= bitIndex + 4'd1;
        if (bitIndex == 4'd0 && rxSync) begin
          busy <= 1'b0;  // glitch, not a real start bit
        end else if (bitIndex == 4'd10) begin
          busy     <= 1'b0;
          rxStrobe <= rxSync;  // low stop bit drops the byte
        end
      end else begin
        tickCount <= tickCount - 1'b1;
      end
    end
  end

  // data path, lsb arrives first
  always_ff @(posedge CLK) begin
    if (sampleNow && bitIndex >= 4'd1 && bitIndex <= 4'd8) begin
      shiftReg <= {rxSync, shiftReg[7:1]};
    end
    if (sampleNow && bitIndex == 4'd10) begin
      rxByte <= shiftReg;
    end
  end

  // a byte takes many bit periods, so strobes can never be adjacent
  strobeIsPulse: assert property (@(posedge CLK) disable iff (!resetn)
    rxStrobe |=> !rxStrobe)
    else $error("uartRx: rxStrobe high on two consecutive cycles");

endmodule

//--- rtl/frameDecoder.sv
module frameDecoder
  import cfgLoadPkg::*;
(
  input  logic        CLK,
  input  logic        resetn,
  input  logic [7:0]  rxByte,
  input  logic        rxStrobe,
  output logic [7:0]  dataByte,
  output logic        byteStrobe,
  output logic [6:0]  opcode,
  output logic        frameStart,
  output logic        frameEnd,
  output logic        badCommand,
  output logic        active,
  output logic [19:0] sum
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_SYNC1,
    S_SYNC2,
    S_CMD,
    S_EVAL,
    S_DATA
  } state_t;

  state_t               state;
  cmdByte_u             cmdReg;
  logic [TIMEOUT_W-1:0] idleCount;
  logic                 timeout;
  logic                 cmdOk;
  logic                 haveHigh;    // first nibble of a hex pair is waiting
  logic [3:0]           highNibble;
  logic [4:0]           nibble;      // bit 4 flags a non-hex character
  logic                 outValid;
  logic [7:0]           outByte;

  function automatic logic [4:0] hexDecode(input logic [7:0] c);
    if (c >= 8'h30 && c <= 8'h39) begin
      return {1'b0, c[3:0]};
    end else if ((c >= 8'h41 && c <= 8'h46) || (c >= 8'h61 && c <= 8'h66)) begin
      return {1'b0, c[3:0] + 4'd9};  // A..F and a..f share the low nibble
    end else begin
      return 5'b10000;
    end
  endfunction

  assign active     = (state == S_DATA);
  assign opcode     = cmdReg.fields.opcode;
  assign cmdOk      = (cmdReg.fields.opcode == 7'd1) || (cmdReg.fields.opcode == 7'd2);
  assign frameStart = (state == S_EVAL) && cmdOk;
  assign badCommand = (state == S_EVAL) && !cmdOk;
  assign timeout    = (state != S_IDLE) && !rxStrobe &&
                      (idleCount == TIMEOUT_W'(TIMEOUT_CYCLES - 1));
  assign nibble     = hexDecode(rxByte);

  // byte produced by this strobe, if any
  always_comb begin
    if (cmdReg.fields.hexMode) begin
      outByte  = {highNibble, nibble[3:0]};
      outValid = active && rxStrobe && !nibble[4] && haveHigh;
    end else begin
      outByte  = rxByte;
      outValid = active && rxStrobe;
    end
  end

  always_ff @(posedge CLK or negedge resetn) begin
    if (!resetn) begin
      state     <= S_IDLE;
      cmdReg    <= '0;
      idleCount <= '0;
      frameEnd  <= 1'b0;
    end else begin
      frameEnd <= 1'b0;
      if (rxStrobe || state == S_IDLE) begin
        idleCount <= '0;  // restart on every byte
      end else begin
        idleCount <= idleCount + 1'b1;
      end
      if (timeout) begin
        state    <= S_IDLE;
        frameEnd <= active;
      end else begin
        case (state)
          S_IDLE: begin
            if (rxStrobe && rxByte == SYNC_HEADER[23:16]) begin
              state <= S_SYNC1;
            end
          end
          S_SYNC1: begin
            if (rxStrobe) begin
              state <= (rxByte == SYNC_HEADER[15:8]) ? S_SYNC2 : S_IDLE;
            end
          end
          S_SYNC2: begin
            if (rxStrobe) begin
              state <= (rxByte == SYNC_HEADER[7:0]) ? S_CMD : S_IDLE;
            end
          end
          S_CMD: begin
            if (rxStrobe) begin
              cmdReg.raw <= rxByte;
              state      <= S_EVAL;
            end
          end
          S_EVAL: state <= cmdOk ? S_DATA : S_IDLE;
          S_DATA: state <= S_DATA;  // left only by timeout
          default: state <= S_IDLE;
        endcase
      end
    end
  end

  always_ff @(posedge CLK or negedge resetn) begin
    if (!resetn) begin
      haveHigh   <= 1'b0;
      byteStrobe <= 1'b0;
      sum        <= '0;
    end else begin
      byteStrobe <= outValid;
      if (frameStart) begin
        sum <= '0;
      end else if (outValid) begin
        sum <= sum + {12'd0, outByte};
      end
      if (!active) begin
        haveHigh <= 1'b0;
      end else if (cmdReg.fields.hexMode && rxStrobe && !nibble[4]) begin
        haveHigh <= !haveHigh;  // junk characters leave the pairing alone
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (active && rxStrobe && !nibble[4] && !haveHigh) begin
      highNibble <= nibble[3:0];
    end
    if (outValid) begin
      dataByte <= outByte;
    end
  end

  strobeInData: assert property (@(posedge CLK) disable iff (!resetn)
    byteStrobe |-> active)
    else $error("frameDecoder: byteStrobe outside the data state");

endmodule

//--- rtl/wordPacker.sv
module wordPacker
  import cfgLoadPkg::*;
(
  input  logic       CLK,
  input  logic       resetn,
  input  logic [7:0] dataByte,
  input  logic       byteStrobe,
  input  logic [6:0] opcode,
  input  logic       frameStart,
  output cfgWord_t   cfgOut,
  output logic       cfgValid,
  input  logic       creditReturn,
  output logic       overflow
);

  logic [1:0]          bytePos;
  logic [23:0]         upperBytes;  // first three bytes of the word
  logic [CREDIT_W-1:0] credits;
  logic                creditAvail;
  logic                wordDone;
  logic                holdValid;
  cfgWord_t            holdWord;
  cfgWord_t            newWord;
  logic                sendHold;
  logic                sendNew;
  logic                loadHold;
  logic                spend;
  logic [CREDIT_W:0]   inFlight;    // words at the sink not yet paid back

  assign wordDone    = byteStrobe && (bytePos == 2'd3);
  assign newWord     = '{data: {upperBytes, dataByte}, opcode: opcode};
  assign creditAvail = (credits != '0) || creditReturn;  // returned credit usable at once
  assign sendHold    = holdValid && creditAvail;
  assign sendNew     = !holdValid && wordDone && creditAvail;
  assign loadHold    = wordDone && (sendHold || (!holdValid && !creditAvail));
  assign spend       = sendHold || sendNew;

  always_ff @(posedge CLK or negedge resetn) begin
    if (!resetn) begin
      bytePos   <= '0;
      credits   <= CREDIT_W'(SINK_CREDITS);
      holdValid <= 1'b0;
      cfgValid  <= 1'b0;
      overflow  <= 1'b0;
    end else begin
      cfgValid <= spend;
      overflow <= wordDone && holdValid && !creditAvail;  // word lost
      credits  <= credits + CREDIT_W'(creditReturn) - CREDIT_W'(spend);
      if (frameStart) begin
        bytePos <= '0;
      end else if (byteStrobe) begin
        bytePos <= bytePos + 2'd1;
      end
      if (loadHold) begin
        holdValid <= 1'b1;
      end else if (sendHold) begin
        holdValid <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (byteStrobe) begin
      upperBytes <= {upperBytes[15:0], dataByte};  // big endian
    end
    if (loadHold) begin
      holdWord <= newWord;
    end
    if (sendHold) begin
      cfgOut <= holdWord;  // oldest word goes first
    end else if (sendNew) begin
      cfgOut <= newWord;
    end
  end

  // words seen on the port minus credits seen on the port
  always_ff @(posedge CLK or negedge resetn) begin
    if (!resetn) begin
      inFlight <= '0;
    end else begin
      inFlight <= inFlight + {{CREDIT_W{1'b0}}, cfgValid} - {{CREDIT_W{1'b0}}, creditReturn};
    end
  end

  creditSpent: assert property (@(posedge CLK) disable iff (!resetn)
    cfgValid |-> inFlight < SINK_CREDITS)
    else $error("wordPacker: cfgValid issued without a credit");

  creditBound: assert property (@(posedge CLK) disable iff (!resetn)
    credits <= SINK_CREDITS)
    else $error("wordPacker: sink returned more credits than granted");

endmodule

//--- rtl/loaderStatus.sv
module loaderStatus
  import cfgLoadPkg::*;
(
  input  logic          CLK,
  input  logic          resetn,
  input  logic          frameStart,
  input  logic          frameEnd,
  input  logic          badCommand,
  input  logic          overflow,
  input  logic          active,
  input  logic [19:0]   sum,
  output loaderStatus_t status,
  output logic          receiveLed
);

  logic [BLINK_W-1:0] blinkCount;  // free running
  logic               badChecksum;

  assign badChecksum = status.frameDone && !status.checksumOk;

  always_ff @(posedge CLK or negedge resetn) begin
    if (!resetn) begin
      status     <= '0;
      receiveLed <= 1'b0;
      blinkCount <= '0;
    end else begin
      blinkCount    <= blinkCount + 1'b1;
      status.active <= active;
      if (frameStart) begin
        status.frameDone  <= 1'b0;  // new frame, forget the last result
        status.checksumOk <= 1'b0;
        status.overflow   <= 1'b0;
        status.badCommand <= 1'b0;
      end else begin
        if (frameEnd) begin
          status.frameDone  <= 1'b1;
          status.checksumOk <= (sum == CHECKSUM_TARGET);
        end
        if (overflow) begin
          status.overflow <= 1'b1;  // sticky
        end
        if (badCommand) begin
          status.badCommand <= 1'b1;  // sticky
        end
      end

      if (active) begin
        receiveLed <= 1'b1;  // receiving
      end else if (badChecksum) begin
        receiveLed <= blinkCount[BLINK_W-1];
      end else begin
        receiveLed <= 1'b0;
      end
    end
  end

endmodule

//--- rtl/configLoader.sv
module configLoader
  import cfgLoadPkg::*;
(
  input  logic          CLK,
  input  logic          resetn,
  input  logic          rx,
  output cfgWord_t      cfgOut,
  output logic          cfgValid,
  input  logic          creditReturn,
  output loaderStatus_t status,
  output logic          receiveLed
);

  logic [7:0]  rxByte;
  logic        rxStrobe;
  logic [7:0]  dataByte;
  logic        byteStrobe;
  logic [6:0]  opcode;
  logic        frameStart;
  logic        frameEnd;
  logic        badCommand;
  logic        active;
  logic [19:0] sum;
  logic        overflow;

  uartRx uRx (
    .CLK      (CLK),
    .resetn   (resetn),
    .rx       (rx),
    .rxByte   (rxByte),
    .rxStrobe (rxStrobe)
  );

  frameDecoder uDecoder (
    .CLK        (CLK),
    .resetn     (resetn),
    .rxByte     (rxByte),
    .rxStrobe   (rxStrobe),
    .dataByte   (dataByte),
    .byteStrobe (byteStrobe),
    .opcode     (opcode),
    .frameStart (frameStart),
    .frameEnd   (frameEnd),
    .badCommand (badCommand),
    .active     (active),
    .sum        (sum)
  );

  wordPacker uPacker (
    .CLK          (CLK),
    .resetn       (resetn),
    .dataByte     (dataByte),
    .byteStrobe   (byteStrobe),
    .opcode       (opcode),
    .frameStart   (frameStart),
    .cfgOut       (cfgOut),
    .cfgValid     (cfgValid),
    .creditReturn (creditReturn),
    .overflow     (overflow)
  );

  loaderStatus uStatus (
    .CLK        (CLK),
    .resetn     (resetn),
    .frameStart (frameStart),
    .frameEnd   (frameEnd),
    .badCommand (badCommand),
    .overflow   (overflow),
    .active     (active),
    .sum        (sum),
    .status     (status),
    .receiveLed (receiveLed)
  );

endmodule

//--- verif/configLoaderTb.sv
module configLoaderTb
  import cfgLoadPkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CHECKSUM_BYTES = int'(CHECKSUM_TARGET) / 255;  // all-FF stream hits the target
  localparam int BYTES_SENT = 1362;  // every byte the five tests put on the line
  localparam int FRAME_WAITS = 5;    // frames that end by inactivity timeout
  localparam int WATCHDOG_NS = (BYTES_SENT * 11 * BIT_PERIOD + FRAME_WAITS * TIMEOUT_CYCLES
                                + 20000) * 8;
  localparam int WORD_WAIT = 4 * 11 * BIT_PERIOD + 100;
  localparam logic [31:0] JUNK_CHARS = 32'h675A203A;  // g Z space colon

  logic          CLK;
  logic          resetn;
  logic          rx;
  logic          creditReturn;
  cfgWord_t      cfgOut;
  logic          cfgValid;
  loaderStatus_t status;
  logic          receiveLed;

  logic [31:0] rngState;
  int          cycleCount;
  int          creditDelay;     // cycles from a word to its credit return
  logic        creditStall;     // holds back all credit returns
  int          valueErrors;
  int          otherErrors;
  logic        lastChecksumOk;
  cfgWord_t    received[$];
  int          returnAt[$];     // cycle at which each spent credit comes back
  logic [7:0]  expBytes[$];     // data bytes of the current frame

  configLoader u_dut (
    .CLK          (CLK),
    .resetn       (resetn),
    .rx           (rx),
    .cfgOut       (cfgOut),
    .cfgValid     (cfgValid),
    .creditReturn (creditReturn),
    .status       (status),
    .receiveLed   (receiveLed)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  always @(posedge CLK) cycleCount <= cycleCount + 1;

  // sink model, samples mid cycle
  always @(negedge CLK) begin
    if (resetn && cfgValid) begin
      received.push_back(cfgOut);
      returnAt.push_back(cycleCount + creditDelay);
    end
  end

  // one credit back per cycle at most
  initial begin
    forever begin
      @(posedge CLK);
      #1;
      if (!creditStall && returnAt.size() > 0 && returnAt[0] <= cycleCount) begin
        creditReturn = 1'b1;
        returnAt.delete(0);
      end else begin
        creditReturn = 1'b0;
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
    $display("TESTS FAILED");
    $finish;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic [7:0] hexChar(input logic [3:0] n, input logic upper);
    if (n < 4'd10) begin
      return 8'h30 + {4'd0, n};
    end else if (upper) begin
      return 8'h41 + {4'd0, n} - 8'd10;
    end else begin
      return 8'h61 + {4'd0, n} - 8'd10;
    end
  endfunction

  function automatic loaderStatus_t makeStatus(input logic act, input logic ok,
                                               input logic done, input logic ovf,
                                               input logic bad);
    loaderStatus_t s;
    s.active     = act;
    s.checksumOk = ok;
    s.frameDone  = done;
    s.overflow   = ovf;
    s.badCommand = bad;
    return s;
  endfunction

  function automatic logic [19:0] byteSum();
    logic [19:0] acc;
    acc = '0;
    foreach (expBytes[i]) acc = acc + {12'd0, expBytes[i]};
    return acc;
  endfunction

  task automatic nextByte(output logic [7:0] b);
    rngState = xorshift(rngState);
    b = rngState[7:0];
  endtask

  // start bit, eight data bits lsb first, two stop bits
  task automatic sendByte(input logic [7:0] b);
    logic [10:0] frame;
    frame = {2'b11, b, 1'b0};
    for (int i = 0; i < 11; i++) begin
      @(posedge CLK);
      #1;
      rx = frame[i];
      repeat (BIT_PERIOD - 1) @(posedge CLK);
    end
  endtask

  task automatic sendHeader(input logic [7:0] cmd);
    sendByte(SYNC_HEADER[23:16]);
    sendByte(SYNC_HEADER[15:8]);
    sendByte(SYNC_HEADER[7:0]);
    sendByte(cmd);
  endtask

  task automatic sendData(input int n);
    logic [7:0] b;
    for (int i = 0; i < n; i++) begin
      nextByte(b);
      expBytes.push_back(b);
      sendByte(b);
    end
  endtask

  task automatic waitWords(input string testName, input int n);
    int cycles;
    cycles = 0;
    while (received.size() < n && cycles < WORD_WAIT) begin
      @(negedge CLK);
      cycles++;
    end
    if (received.size() < n) begin
      otherErrors++;
      $display("%s: only %0d of %0d words reached the sink in time", testName,
               received.size(), n);
    end
  endtask

  task automatic waitStatus(input string testName, input loaderStatus_t mask, input int limit);
    int cycles;
    cycles = 0;
    while ((status & mask) != mask && cycles < limit) begin
      @(negedge CLK);
      cycles++;
    end
    if ((status & mask) != mask) begin
      otherErrors++;
      $display("%s: status bits %b never came up", testName, mask);
    end
  endtask

  task automatic checkWord(input string testName, input cfgWord_t expected,
                           input cfgWord_t actual);
    if (actual !== expected) begin
      valueErrors++;
      $display("Fail %s: expected data %h op %h, actual data %h op %h", testName,
               expected.data, expected.opcode, actual.data, actual.opcode);
    end
  endtask

  task automatic checkStatus(input string testName, input loaderStatus_t expected,
                             input loaderStatus_t actual);
    if (actual !== expected) begin
      valueErrors++;
      $display("Fail %s: expected status %b, actual %b", testName, expected, actual);
    end
  endtask

  task automatic checkLed(input string testName, input logic expected, input logic actual);
    if (actual !== expected) begin
      valueErrors++;
      $display("Fail %s: expected led %b, actual %b", testName, expected, actual);
    end
  endtask

  task automatic checkCount(input string testName, input int expected, input int actual);
    if (actual != expected) begin
      valueErrors++;
      $display("Fail %s: expected %0d words, actual %0d", testName, expected, actual);
    end
  endtask

  // words first .. first+count-1 against the bytes sent, big endian
  task automatic checkWords(input string testName, input int first, input int count,
                            input logic [6:0] op);
    cfgWord_t expected;
    int       b;
    for (int i = first; i < first + count && i < received.size(); i++) begin
      b = 4 * i;
      expected.data   = {expBytes[b], expBytes[b + 1], expBytes[b + 2], expBytes[b + 3]};
      expected.opcode = op;
      checkWord(testName, expected, received[i]);
    end
  endtask

  task automatic testBinaryFrame();
    received.delete();
    expBytes.delete();
    sendHeader(8'h01);
    sendData(8);
    waitWords("binaryFrame", 2);
    checkCount("binaryFrame", 2, received.size());
    checkWords("binaryFrame", 0, 2, 7'd1);
    waitStatus("binaryFrame", makeStatus(0, 0, 1, 0, 0), TIMEOUT_CYCLES + 100);
    checkStatus("binaryFrame", makeStatus(0, byteSum() == CHECKSUM_TARGET, 1, 0, 0), status);
  endtask

  task automatic testHexFrame();
    logic [7:0] b;
    received.delete();
    expBytes.delete();
    sendHeader(8'h82);
    for (int i = 0; i < 8; i++) begin
      nextByte(b);
      expBytes.push_back(b);
      sendByte(hexChar(b[7:4], rngState[9]));  // case picked at random
      if (i % 2 == 1) begin
        sendByte(JUNK_CHARS[8 * (i / 2) +: 8]);  // junk inside a pair
      end
      sendByte(hexChar(b[3:0], rngState[10]));
    end
    waitWords("hexFrame", 2);
    checkCount("hexFrame", 2, received.size());
    checkWords("hexFrame", 0, 2, 7'd2);
    waitStatus("hexFrame", makeStatus(0, 0, 1, 0, 0), TIMEOUT_CYCLES + 100);
    lastChecksumOk = (byteSum() == CHECKSUM_TARGET);
    checkStatus("hexFrame", makeStatus(0, lastChecksumOk, 1, 0, 0), status);
  endtask

  task automatic testRejection();
    received.delete();
    sendByte(SYNC_HEADER[23:16]);
    sendByte(8'h55);  // wrong second sync byte
    sendHeader(8'h05);
    waitStatus("rejection", makeStatus(0, 0, 0, 0, 1), 200);
    sendByte(8'h12);  // a full word's worth after the rejected command
    sendByte(8'h34);
    sendByte(8'h56);
    sendByte(8'h78);
    repeat (20) @(negedge CLK);
    checkCount("rejection", 0, received.size());
    checkStatus("rejection", makeStatus(0, lastChecksumOk, 1, 0, 1), status);
  endtask

  task automatic testChecksum();
    received.delete();
    expBytes.delete();
    sendHeader(8'h01);
    for (int i = 0; i < CHECKSUM_BYTES; i++) begin
      expBytes.push_back(8'hFF);
      sendByte(8'hFF);
    end
    waitWords("checksumGood", CHECKSUM_BYTES / 4);
    checkCount("checksumGood", CHECKSUM_BYTES / 4, received.size());
    checkWords("checksumGood", 0, CHECKSUM_BYTES / 4, 7'd1);
    waitStatus("checksumGood", makeStatus(0, 0, 1, 0, 0), TIMEOUT_CYCLES + 100);
    checkStatus("checksumGood", makeStatus(0, 1, 1, 0, 0), status);
    checkLed("checksumGood", 1'b0, receiveLed);  // good frame leaves the led dark

    received.delete();
    expBytes.delete();
    sendHeader(8'h01);
    sendData(8);  // far below the target sum
    waitWords("checksumBad", 2);
    waitStatus("checksumBad", makeStatus(0, 0, 1, 0, 0), TIMEOUT_CYCLES + 100);
    checkStatus("checksumBad", makeStatus(0, 0, 1, 0, 0), status);
  endtask

  task automatic testBackPressure();
    received.delete();
    expBytes.delete();
    creditStall = 1'b1;
    sendHeader(8'h02);
    sendData(16);
    waitStatus("backPressure", makeStatus(0, 0, 0, 1, 0), WORD_WAIT);
    repeat (4) @(negedge CLK);
    checkCount("backPressure", SINK_CREDITS, received.size());
    checkWords("backPressure", 0, SINK_CREDITS, 7'd2);
    checkStatus("backPressure", makeStatus(1, 0, 0, 1, 0), status);
    checkLed("backPressure", 1'b1, receiveLed);  // lit while receiving
    creditStall = 1'b0;  // held word should follow the first credit
    waitWords("backPressure", SINK_CREDITS + 1);
    checkWords("backPressure", SINK_CREDITS, 1, 7'd2);
    waitStatus("backPressure", makeStatus(0, 0, 1, 0, 0), TIMEOUT_CYCLES + 100);
    checkCount("backPressure", SINK_CREDITS + 1, received.size());
    checkStatus("backPressure", makeStatus(0, 0, 1, 1, 0), status);
  endtask

  initial begin
    resetn         = 1'b0;
    rx             = 1'b1;
    creditReturn   = 1'b0;
    creditStall    = 1'b0;
    creditDelay    = 3;
    cycleCount     = 0;
    valueErrors    = 0;
    otherErrors    = 0;
    lastChecksumOk = 1'b0;
    rngState       = 32'd82063;
    repeat (2) @(posedge CLK);
    #1;
    resetn = 1'b1;
    repeat (5) @(posedge CLK);

    testBinaryFrame();
    testHexFrame();
    testRejection();
    testChecksum();
    testBackPressure();

    $display("errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
    if (valueErrors + otherErrors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- project.f
rtl/cfgLoadPkg.sv
rtl/uartRx.sv
rtl/frameDecoder.sv
rtl/wordPacker.sv
rtl/loaderStatus.sv
rtl/configLoader.sv
verif/configLoaderTb.sv

//--- Bender.yml
package:
  name: configLoader

sources:
  - files:
      - rtl/cfgLoadPkg.sv
      - rtl/uartRx.sv
      - rtl/frameDecoder.sv
      - rtl/wordPacker.sv
      - rtl/loaderStatus.sv
      - rtl/configLoader.sv
  - target: simulation
    files:
      - verif/configLoaderTb.sv
